//--- flist.f
hdl/job_regfile_pkg.sv
hdl/reg_access_if.sv
hdl/regfile_ctrl.sv
hdl/param_store.sv
hdl/job_status.sv
hdl/job_regfile_top.sv
tb/job_regfile_properties.sv
tb/job_regfile_tb.sv

//--- hdl/job_regfile_pkg.sv
// Shared types and register map; at most four contexts, eight I/O and eight generic words
`default_nettype none

package job_regfile_pkg;

  // Word types
  typedef logic [31:0] data_t;   // Register word
  typedef logic [5:0]  addr_t;   // Word address
  typedef logic [3:0]  be_t;     // Byte enables
  typedef logic [7:0]  job_id_t; // Offload and running job ids
  typedef logic [1:0]  cxt_t;    // Context index
  typedef logic [31:0] status_t; // One busy byte per context

  // Mandatory registers, addresses 5 to 7 are unmapped
  localparam addr_t REG_TRIGGER  = 6'd0;
  localparam addr_t REG_ACQUIRE  = 6'd1;
  localparam addr_t REG_FINISHED = 6'd2;
  localparam addr_t REG_STATUS   = 6'd3;
  localparam addr_t REG_RUNNING  = 6'd4;

  // Bank bases, both aligned to eight words
  localparam addr_t GENERIC_BASE = 6'd8;
  localparam addr_t IO_BASE      = 6'd16;

  // Response codes
  localparam data_t RESP_ALL_CXT_BUSY = '1;
  localparam data_t UNKNOWN_RDATA     = 32'hdeadbeef;

  // Finished counter saturates here
  localparam logic [1:0] FINISHED_MAX = 2'd2;

  localparam logic [7:0] STATUS_BUSY = 8'h01; // Status byte of a busy context

  // Source of the word returned on a read
  typedef enum logic [2:0] {
    RD_RESP,     // Acquire response or fixed code
    RD_STATUS,
    RD_RUNNING,
    RD_FINISHED,
    RD_STORE     // Parameter store read data
  } rd_src_e;

endpackage

`default_nettype wire

//--- hdl/job_regfile_top.sv
// Job offload register file top; N_CONTEXT 1 to 4, up to eight I/O and generic words
`timescale 1ns/1ps
`default_nettype none

module job_regfile_top #(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_IO_REGS      = 4,
  parameter int unsigned N_GENERIC_REGS = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        clear_i,
  input  logic                                        req_i,
  input  logic                                        wren_i,
  input  job_regfile_pkg::addr_t                      addr_i,
  input  job_regfile_pkg::data_t                      wdata_i,
  input  job_regfile_pkg::be_t                        be_i,
  output job_regfile_pkg::data_t                      rdata_o,
  input  logic                                        done_i,
  output job_regfile_pkg::data_t [N_IO_REGS-1:0]      job_params_o,
  output job_regfile_pkg::data_t [N_GENERIC_REGS-1:0] generic_params_o
);

  logic                     trigger, done, finished_clr;
  job_regfile_pkg::cxt_t    pointer_cxt, running_cxt;
  job_regfile_pkg::status_t status;
  job_regfile_pkg::job_id_t running_id;
  logic [1:0]               finished;

  reg_access_if acc ();

  regfile_ctrl #(
    .N_CONTEXT      ( N_CONTEXT      ),
    .N_IO_REGS      ( N_IO_REGS      ),
    .N_GENERIC_REGS ( N_GENERIC_REGS )
  ) i_regfile_ctrl (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .clear_i        ( clear_i      ),
    .req_i          ( req_i        ),
    .wren_i         ( wren_i       ),
    .addr_i         ( addr_i       ),
    .wdata_i        ( wdata_i      ),
    .be_i           ( be_i         ),
    .done_i         ( done_i       ),
    .rdata_o        ( rdata_o      ),
    .acc            ( acc.ctrl     ),
    .trigger_o      ( trigger      ),
    .done_o         ( done         ),
    .finished_clr_o ( finished_clr ),
    .pointer_cxt_o  ( pointer_cxt  ),
    .running_cxt_o  ( running_cxt  ),
    .status_i       ( status       ),
    .running_id_i   ( running_id   ),
    .finished_i     ( finished     )
  );

  param_store #(
    .N_CONTEXT      ( N_CONTEXT      ),
    .N_IO_REGS      ( N_IO_REGS      ),
    .N_GENERIC_REGS ( N_GENERIC_REGS )
  ) i_param_store (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .clear_i          ( clear_i          ),
    .acc              ( acc.store        ),
    .running_cxt_i    ( running_cxt      ),
    .job_params_o     ( job_params_o     ),
    .generic_params_o ( generic_params_o )
  );

  job_status #(
    .N_CONTEXT ( N_CONTEXT )
  ) i_job_status (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .clear_i        ( clear_i      ),
    .trigger_i      ( trigger      ),
    .done_i         ( done         ),
    .finished_clr_i ( finished_clr ),
    .pointer_cxt_i  ( pointer_cxt  ),
    .running_cxt_i  ( running_cxt  ),
    .status_o       ( status       ),
    .running_id_o   ( running_id   ),
    .finished_o     ( finished     )
  );

endmodule

`default_nettype wire

//--- hdl/job_status.sv
// Busy bytes, running id and finished count; status bytes at or above N_CONTEXT read zero
`timescale 1ns/1ps
`default_nettype none

module job_status #(
  parameter int unsigned N_CONTEXT = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      trigger_i,
  input  logic                      done_i,
  input  logic                      finished_clr_i,
  input  job_regfile_pkg::cxt_t     pointer_cxt_i,
  input  job_regfile_pkg::cxt_t     running_cxt_i,
  output job_regfile_pkg::status_t  status_o,
  output job_regfile_pkg::job_id_t  running_id_o,
  output logic [1:0]                finished_o
);

  logic [N_CONTEXT-1:0]     busy_q;
  logic                     done_q;        // Done delayed by one cycle
  job_regfile_pkg::job_id_t running_id_q;
  logic [1:0]               finished_q;

  // Trigger and done cannot hit the same context in one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
    end else if (clear_i) begin
      busy_q <= '0;
    end else begin
      for (int c = 0; c < N_CONTEXT; c++) begin
        if (trigger_i && pointer_cxt_i == c) busy_q[c] <= 1'b1;
        else if (done_i && running_cxt_i == c) busy_q[c] <= 1'b0;
      end
    end
  end

  for (genvar c = 0; c < 4; c++) begin : g_status
    if (c < N_CONTEXT) begin : g_used
      assign status_o[8*c +: 8] = busy_q[c] ? job_regfile_pkg::STATUS_BUSY : 8'h00;
    end else begin : g_unused
      assign status_o[8*c +: 8] = 8'h00;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q       <= 1'b0;
      running_id_q <= '0;
    end else if (clear_i) begin
      done_q       <= 1'b0;
      running_id_q <= '0;
    end else begin
      done_q <= done_i;
      if (done_q) running_id_q <= running_id_q + 1'b1;
    end
  end

  // Clear on read wins over a concurrent increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      finished_q <= '0;
    end else if (clear_i || finished_clr_i) begin
      finished_q <= '0;
    end else if (done_q && finished_q < job_regfile_pkg::FINISHED_MAX) begin
      finished_q <= finished_q + 1'b1;
    end
  end

  assign running_id_o = running_id_q;
  assign finished_o   = finished_q;

endmodule

`default_nettype wire

//--- hdl/param_store.sv
// I/O and generic parameter words in flip-flops; indices are assumed in range from the decoder
`timescale 1ns/1ps
`default_nettype none

module param_store #(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_IO_REGS      = 4,
  parameter int unsigned N_GENERIC_REGS = 2
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           clear_i,
  reg_access_if.store                                    acc,
  input  job_regfile_pkg::cxt_t                          running_cxt_i,
  output job_regfile_pkg::data_t [N_IO_REGS-1:0]         job_params_o,
  output job_regfile_pkg::data_t [N_GENERIC_REGS-1:0]    generic_params_o
);

  job_regfile_pkg::data_t [N_CONTEXT-1:0][N_IO_REGS-1:0] io_q;
  job_regfile_pkg::data_t [N_GENERIC_REGS-1:0]           gen_q;
  job_regfile_pkg::data_t                                rdata_q;

  // Byte-enabled merge of a write into a stored word
  function automatic job_regfile_pkg::data_t merge_bytes(
    job_regfile_pkg::data_t old_word,
    job_regfile_pkg::data_t new_word,
    job_regfile_pkg::be_t   be
  );
    job_regfile_pkg::data_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // I/O bank, one set of words per context
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      io_q <= '0;
    end else if (clear_i) begin
      io_q <= '0;
    end else if (acc.wr && !acc.is_generic) begin
      for (int c = 0; c < N_CONTEXT; c++) begin
        for (int r = 0; r < N_IO_REGS; r++) begin
          if (acc.cxt == c && acc.index == r) begin
            io_q[c][r] <= merge_bytes(io_q[c][r], acc.wdata, acc.be);
          end
        end
      end
    end
  end

  // Generic bank, shared by all contexts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gen_q <= '0;
    end else if (clear_i) begin
      gen_q <= '0;
    end else if (acc.wr && acc.is_generic) begin
      for (int r = 0; r < N_GENERIC_REGS; r++) begin
        if (acc.index == r) gen_q[r] <= merge_bytes(gen_q[r], acc.wdata, acc.be);
      end
    end
  end

  // Read word held until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (clear_i) begin
      rdata_q <= '0;
    end else if (acc.rd) begin
      rdata_q <= acc.is_generic ? gen_q[acc.index] : io_q[acc.cxt][acc.index];
    end
  end

  assign acc.rdata        = rdata_q;
  assign job_params_o     = io_q[running_cxt_i]; // Follows the running job
  assign generic_params_o = gen_q;

endmodule

`default_nettype wire

//--- hdl/reg_access_if.sv
// Parameter register access path; index addresses at most eight words per bank
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if;

  logic                   wr;         // Write strobe
  logic                   rd;         // Read strobe
  logic                   is_generic; // Generic bank instead of I/O bank
  logic [2:0]             index;      // Word within the bank
  job_regfile_pkg::cxt_t  cxt;        // Context of the I/O access
  job_regfile_pkg::data_t wdata;
  job_regfile_pkg::be_t   be;
  job_regfile_pkg::data_t rdata;      // Valid one cycle after rd

  modport ctrl (
    output wr, rd, is_generic, index, cxt, wdata, be,
    input  rdata
  );

  modport store (
    input  wr, rd, is_generic, index, cxt, wdata, be,
    output rdata
  );

endinterface

`default_nettype wire

//--- hdl/regfile_ctrl.sv
// Bus decode and read path; single offloader, one-cycle read latency, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module regfile_ctrl #(
  parameter int unsigned N_CONTEXT      = 2,
  parameter int unsigned N_IO_REGS      = 4,
  parameter int unsigned N_GENERIC_REGS = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      req_i,
  input  logic                      wren_i,
  input  job_regfile_pkg::addr_t    addr_i,
  input  job_regfile_pkg::data_t    wdata_i,
  input  job_regfile_pkg::be_t      be_i,
  input  logic                      done_i,
  output job_regfile_pkg::data_t    rdata_o,
  reg_access_if.ctrl                acc,
  output logic                      trigger_o,
  output logic                      done_o,
  output logic                      finished_clr_o,
  output job_regfile_pkg::cxt_t     pointer_cxt_o,
  output job_regfile_pkg::cxt_t     running_cxt_o,
  input  job_regfile_pkg::status_t  status_i,
  input  job_regfile_pkg::job_id_t  running_id_i,
  input  logic [1:0]                finished_i
);

  job_regfile_pkg::cxt_t   pointer_cxt_q, running_cxt_q;
  job_regfile_pkg::job_id_t offload_id_q;
  job_regfile_pkg::rd_src_e rd_src_d, rd_src_q;
  job_regfile_pkg::data_t  resp_d, resp_q;
  job_regfile_pkg::data_t  fixed_resp;
  logic is_read, is_write;
  logic is_generic, is_io;
  logic pointer_busy, running_busy;

  // Wraps a context counter at N_CONTEXT
  function automatic job_regfile_pkg::cxt_t next_cxt(job_regfile_pkg::cxt_t cxt);
    if (cxt == job_regfile_pkg::cxt_t'(N_CONTEXT - 1)) begin
      return '0;
    end
    return cxt + 1'b1;
  endfunction

  assign is_read  = req_i & ~wren_i;
  assign is_write = req_i & wren_i;

  assign is_generic = (addr_i >= job_regfile_pkg::GENERIC_BASE) &&
                      (addr_i <  job_regfile_pkg::GENERIC_BASE + N_GENERIC_REGS);
  assign is_io      = (addr_i >= job_regfile_pkg::IO_BASE) &&
                      (addr_i <  job_regfile_pkg::IO_BASE + N_IO_REGS);

  assign pointer_busy = status_i[8*pointer_cxt_q +: 8] != 8'h00;
  assign running_busy = status_i[8*running_cxt_q +: 8] != 8'h00;

  // Parameter store access, I/O words always target the pointer context
  assign acc.wr         = is_write & (is_generic | is_io);
  assign acc.rd         = is_read & (is_generic | is_io);
  assign acc.is_generic = is_generic;
  assign acc.index      = addr_i[2:0]; // Low bits suffice since bases are aligned
  assign acc.cxt        = pointer_cxt_q;
  assign acc.wdata      = wdata_i;
  assign acc.be         = be_i;

  assign trigger_o      = is_write && (addr_i == job_regfile_pkg::REG_TRIGGER) && !pointer_busy;
  assign done_o         = done_i & running_busy; // Spurious done is dropped
  assign finished_clr_o = is_read && (addr_i == job_regfile_pkg::REG_FINISHED);
  assign pointer_cxt_o  = pointer_cxt_q;
  assign running_cxt_o  = running_cxt_q;

  // Context pointers and offload id; an id is consumed when its job is triggered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pointer_cxt_q <= '0;
      running_cxt_q <= '0;
      offload_id_q  <= '0;
    end else if (clear_i) begin
      pointer_cxt_q <= '0;
      running_cxt_q <= '0;
      offload_id_q  <= '0;
    end else begin
      if (trigger_o) begin
        pointer_cxt_q <= next_cxt(pointer_cxt_q);
        offload_id_q  <= offload_id_q + 1'b1;
      end
      if (done_o) running_cxt_q <= next_cxt(running_cxt_q);
    end
  end

  always_comb begin
    if (addr_i == job_regfile_pkg::REG_ACQUIRE) begin
      fixed_resp = pointer_busy ? job_regfile_pkg::RESP_ALL_CXT_BUSY
                                : job_regfile_pkg::data_t'(offload_id_q);
    end else if (addr_i == job_regfile_pkg::REG_TRIGGER) begin
      fixed_resp = '0;
    end else begin
      fixed_resp = job_regfile_pkg::UNKNOWN_RDATA;
    end
  end

  always_comb begin
    rd_src_d = job_regfile_pkg::RD_RESP;
    if (is_generic || is_io) rd_src_d = job_regfile_pkg::RD_STORE;
    else if (addr_i == job_regfile_pkg::REG_STATUS) rd_src_d = job_regfile_pkg::RD_STATUS;
    else if (addr_i == job_regfile_pkg::REG_RUNNING) rd_src_d = job_regfile_pkg::RD_RUNNING;
    else if (addr_i == job_regfile_pkg::REG_FINISHED) rd_src_d = job_regfile_pkg::RD_FINISHED;
  end

  // Snapshot at the read edge, finished count is cleared on that same edge
  always_comb begin
    case (rd_src_d)
      job_regfile_pkg::RD_STATUS:   resp_d = status_i;
      job_regfile_pkg::RD_RUNNING:  resp_d = job_regfile_pkg::data_t'(running_id_i);
      job_regfile_pkg::RD_FINISHED: resp_d = job_regfile_pkg::data_t'(finished_i);
      job_regfile_pkg::RD_STORE:    resp_d = '0; // Store returns its own word
      default:                      resp_d = fixed_resp;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_src_q <= job_regfile_pkg::RD_RESP;
      resp_q   <= '0;
    end else if (clear_i) begin
      rd_src_q <= job_regfile_pkg::RD_RESP;
      resp_q   <= '0;
    end else if (is_read) begin
      rd_src_q <= rd_src_d;
      resp_q   <= resp_d;
    end
  end

  assign rdata_o = (rd_src_q == job_regfile_pkg::RD_STORE) ? acc.rdata : resp_q;

endmodule

`default_nettype wire

//--- tb/job_regfile_golden.txt
# Columns: op addr data be expected, all fields hex
# Ops: W write, R read and compare, D done pulse, C clear pulse, J/G job/generic word at index addr
R 03 00000000 0 00000000
R 04 00000000 0 00000000
R 02 00000000 0 00000000
R 05 00000000 0 deadbeef
J 00 00000000 0 00000000
J 03 00000000 0 00000000
W 08 11223344 f 00000000
W 08 aabbccdd 5 00000000
R 08 00000000 0 11bb33dd
W 09 cafef00d c 00000000
R 09 00000000 0 cafe0000
G 00 00000000 0 11bb33dd
G 01 00000000 0 cafe0000
W 10 01020304 f 00000000
W 13 a5a5a5a5 3 00000000
R 10 00000000 0 01020304
R 13 00000000 0 0000a5a5
J 00 00000000 0 01020304
J 03 00000000 0 0000a5a5
R 01 00000000 0 00000000
W 00 00000000 f 00000000
W 10 55667788 f 00000000
W 11 0badc0de 2 00000000
R 11 00000000 0 0000c000
J 00 00000000 0 01020304
R 01 00000000 0 00000001
W 00 00000000 f 00000000
R 03 00000000 0 00000101
R 01 00000000 0 ffffffff
W 00 00000000 f 00000000
R 03 00000000 0 00000101
R 01 00000000 0 ffffffff
D 00 00000000 0 00000000
R 03 00000000 0 00000100
R 04 00000000 0 00000001
J 00 00000000 0 55667788
J 01 00000000 0 0000c000
J 03 00000000 0 00000000
R 01 00000000 0 00000002
W 00 00000000 f 00000000
D 00 00000000 0 00000000
D 00 00000000 0 00000000
D 00 00000000 0 00000000
R 04 00000000 0 00000003
R 02 00000000 0 00000002
R 02 00000000 0 00000000
R 03 00000000 0 00000000
R 01 00000000 0 00000003
W 00 00000000 f 00000000
R 03 00000000 0 00000100
C 00 00000000 0 00000000
R 03 00000000 0 00000000
R 04 00000000 0 00000000
R 02 00000000 0 00000000
R 08 00000000 0 00000000
J 00 00000000 0 00000000
G 00 00000000 0 00000000
G 01 00000000 0 00000000
R 01 00000000 0 00000000

//--- tb/job_regfile_properties.sv
// Assertions bound into job_regfile_top; the acquire check assumes a single offloader
`timescale 1ns/1ps
`default_nettype none

module job_regfile_properties #(
  parameter int unsigned N_CONTEXT = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     req_i,
  input  logic                     wren_i,
  input  job_regfile_pkg::addr_t   addr_i,
  input  logic                     done_i,
  input  job_regfile_pkg::data_t   rdata_i,
  input  job_regfile_pkg::status_t status_i,
  input  logic [1:0]               finished_i
);

  logic                   acq_q;        // Acquire read accepted at the last edge
  logic                   event_q;
  logic                   last_valid_q;
  job_regfile_pkg::data_t last_acq_q;
  logic                   acq_event;    // Anything that may change the acquire response

  // A trigger after an all-busy response hits a busy context and is ignored
  assign acq_event = clear_i | done_i |
                     (req_i & wren_i & (addr_i == job_regfile_pkg::REG_TRIGGER) &
                      !(last_valid_q && last_acq_q == job_regfile_pkg::RESP_ALL_CXT_BUSY));

  // Remembers the last acquire response until a trigger, done or clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acq_q        <= 1'b0;
      event_q      <= 1'b0;
      last_valid_q <= 1'b0;
      last_acq_q   <= '0;
    end else begin
      acq_q   <= req_i & ~wren_i & (addr_i == job_regfile_pkg::REG_ACQUIRE);
      event_q <= acq_event;
      if (acq_event) begin
        last_valid_q <= 1'b0;
      end else if (acq_q && !event_q) begin // Response taken before any change
        last_valid_q <= 1'b1;
        last_acq_q   <= rdata_i;
      end
    end
  end

  rdata_zero_in_reset: assert property (@(posedge clk_i) !rst_ni |-> rdata_i == '0)
    else $error("rdata_o is not zero during reset");

  unused_status_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (status_i >> (8 * N_CONTEXT)) == '0)
    else $error("status byte of a context that does not exist is set");

  finished_bounded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    finished_i <= job_regfile_pkg::FINISHED_MAX)
    else $error("finished count is above its saturation value");

  acquire_repeats: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acq_q && last_valid_q |-> rdata_i == last_acq_q)
    else $error("two acquires without a trigger returned different values");

endmodule

bind job_regfile_top job_regfile_properties #(
  .N_CONTEXT ( N_CONTEXT )
) i_job_regfile_properties (
  .clk_i      ( clk_i    ),
  .rst_ni     ( rst_ni   ),
  .clear_i    ( clear_i  ),
  .req_i      ( req_i    ),
  .wren_i     ( wren_i   ),
  .addr_i     ( addr_i   ),
  .done_i     ( done_i   ),
  .rdata_i    ( rdata_o  ),
  .status_i   ( status   ),
  .finished_i ( finished )
);

`default_nettype wire

//--- tb/job_regfile_tb.sv
// Plays tb/job_regfile_golden.txt, relative to the project root, against the default configuration
`timescale 1ns/1ps
`default_nettype none

module job_regfile_tb;

  localparam int unsigned N_CONTEXT      = 2;
  localparam int unsigned N_IO_REGS      = 4;
  localparam int unsigned N_GENERIC_REGS = 2;
  localparam int unsigned MAX_LINES      = 1000; // Bound for the file player loop

  logic                                        clk_i;
  logic                                        rst_ni;
  logic                                        clear_i;
  logic                                        req_i;
  logic                                        wren_i;
  job_regfile_pkg::addr_t                      addr_i;
  job_regfile_pkg::data_t                      wdata_i;
  job_regfile_pkg::be_t                        be_i;
  logic                                        done_i;
  job_regfile_pkg::data_t                      rdata_o;
  job_regfile_pkg::data_t [N_IO_REGS-1:0]      job_params_o;
  job_regfile_pkg::data_t [N_GENERIC_REGS-1:0] generic_params_o;

  int unsigned num_errors;
  int unsigned num_checks;

  job_regfile_top #(
    .N_CONTEXT      ( N_CONTEXT      ),
    .N_IO_REGS      ( N_IO_REGS      ),
    .N_GENERIC_REGS ( N_GENERIC_REGS )
  ) i_job_regfile_top (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .clear_i          ( clear_i          ),
    .req_i            ( req_i            ),
    .wren_i           ( wren_i           ),
    .addr_i           ( addr_i           ),
    .wdata_i          ( wdata_i          ),
    .be_i             ( be_i             ),
    .rdata_o          ( rdata_o          ),
    .done_i           ( done_i           ),
    .job_params_o     ( job_params_o     ),
    .generic_params_o ( generic_params_o )
  );

  always #5 clk_i = ~clk_i; // 10 ns period

  task automatic check_value(input string name, input job_regfile_pkg::data_t expected,
                             input job_regfile_pkg::data_t actual);
    num_checks++;
    if (actual !== expected) begin
      num_errors++;
      $display("mismatch %s expected %08h actual %08h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    num_errors++;
    $display("error: %s", what);
  endtask

  task automatic idle_inputs();
    req_i   = 1'b0;
    wren_i  = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    done_i  = 1'b0;
    clear_i = 1'b0;
  endtask

  // Each operation lasts two cycles so that the delayed done counters settle
  task automatic run_op(input byte op, input logic [31:0] addr, input logic [31:0] data,
                        input logic [31:0] be, input logic [31:0] expected, input int line_no);
    string name;
    name = $sformatf("line %0d op %c addr %02h", line_no, op, addr);
    case (op)
      "W": begin
        req_i   = 1'b1;
        wren_i  = 1'b1;
        addr_i  = job_regfile_pkg::addr_t'(addr);
        wdata_i = data;
        be_i    = job_regfile_pkg::be_t'(be);
      end
      "R": begin
        req_i  = 1'b1;
        addr_i = job_regfile_pkg::addr_t'(addr);
      end
      "D": done_i = 1'b1;
      "C": clear_i = 1'b1;
      "J", "G": ; // Outputs only, checked below
      default: report_failure($sformatf("unknown operation %c on golden line %0d", op, line_no));
    endcase
    @(negedge clk_i);
    if (op == "R") check_value(name, expected, rdata_o); // Read data is held after the edge
    if (op == "J") begin
      if (addr < N_IO_REGS) check_value(name, expected, job_params_o[addr]);
      else report_failure($sformatf("job parameter index out of range on line %0d", line_no));
    end
    if (op == "G") begin
      if (addr < N_GENERIC_REGS) check_value(name, expected, generic_params_o[addr]);
      else report_failure($sformatf("generic index out of range on line %0d", line_no));
    end
    idle_inputs();
    @(negedge clk_i);
  endtask

  initial begin : player
    int          fd;
    int          line_no;
    int          n_fields;
    bit          at_end;
    string       line;
    byte         op;
    logic [31:0] addr, data, be, expected;
    num_errors = 0;
    num_checks = 0;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    idle_inputs();
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    fd = $fopen("tb/job_regfile_golden.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open tb/job_regfile_golden.txt");
    end else begin
      line_no = 0;
      at_end  = 1'b0;
      while (!at_end) begin
        if (line_no >= MAX_LINES) begin
          report_failure("golden file player timed out before the end of the file");
          at_end = 1'b1;
        end else if ($fgets(line, fd) == 0) begin
          at_end = 1'b1;
        end else begin
          line_no++;
          if (line.len() > 1 && line.getc(0) != "#") begin // Skip comments and blank lines
            n_fields = $sscanf(line, "%c %h %h %h %h", op, addr, data, be, expected);
            if (n_fields == 5) run_op(op, addr, data, be, expected, line_no);
            else report_failure($sformatf("malformed golden line %0d", line_no));
          end
        end
      end
      $fclose(fd);
    end
    if (num_checks == 0) report_failure("no checks were run");
    $display("checks %0d, errors %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
